/* kl10TypesPkg.sv */
`default_nettype none

package kl10TypesPkg;

  // Machine word, big-endian numbering.
  typedef logic [0:35] tWord;

  // Virtual address as the EBOX sees it.
  typedef logic [13:35] tVirtAdr;

  // Physical address sent to the memory box.
  typedef logic [14:35] tPhysAdr;

  // Page index, virtual address bits 18 to 26.
  typedef logic [18:26] tPageNum;

  // Physical page, top of the physical address.
  typedef logic [14:26] tPhysPage;

  // One page map entry.
  typedef struct packed {
    logic     accessible;
    logic     public;
    logic     writable;
    logic     cacheable;
    tPhysPage physPage;
  } tPageEntry;

  // Map size, one entry per virtual page.
  localparam int pageCount = 512;

  // Highest fast-memory address.
  localparam int acLimit = 'o17;

endpackage

`default_nettype wire

/* memRefPkg.sv */
`default_nettype none

package memRefPkg;

  // Reference strobe from the microcode side.
  typedef struct packed {
    logic                 valid;
    logic                 read;
    logic                 write;
    logic                 user;
    logic                 paged;
    kl10TypesPkg::tVirtAdr virtAdr;
  } tMemRefCmd;

  // Address held and classified by the VMA.
  typedef struct packed {
    logic                 valid;
    logic                 read;
    logic                 write;
    logic                 user;
    logic                 paged;
    logic                 acRef;
    kl10TypesPkg::tVirtAdr virtAdr;
  } tVmaState;

  // Registered pager result.
  typedef struct packed {
    logic                   valid;
    logic                   present;
    kl10TypesPkg::tPageEntry entry;
  } tPageLookup;

  // Page-fail reasons.
  typedef enum logic [2:0] {
    pfNone,
    pfNoAccess,
    pfNotPublic,
    pfWriteProtect,
    pfUnmapped
  } tPageFailCode;

endpackage

`default_nettype wire

/* vma.sv */
`timescale 1ns/1ps
`default_nettype none

module vma (
  input  wire                 eboxClk,
  input  wire                 rstN,
  input  memRefPkg::tMemRefCmd memRef,
  output memRefPkg::tVmaState  vmaOut
);

  import kl10TypesPkg::*;

  logic    validQ;
  logic    readQ;
  logic    writeQ;
  logic    userQ;
  logic    pagedQ;
  logic    acRefQ;
  tVirtAdr virtAdrQ;

  logic    acClass;

  // Section bits clear and offset within the AC block.
  always_comb begin
    acClass = (memRef.virtAdr[13:17] == 5'b0) &&
              (memRef.virtAdr[18:35] <= 18'(acLimit));
  end

  always_ff @(posedge eboxClk) begin
    if (!rstN) begin
      validQ <= 1'b0;
    end else begin
      validQ <= memRef.valid;
    end
  end

  // Address and flags hold until the next strobe.
  always_ff @(posedge eboxClk) begin
    if (memRef.valid) begin
      readQ    <= memRef.read;
      writeQ   <= memRef.write;
      userQ    <= memRef.user;
      pagedQ   <= memRef.paged;
      acRefQ   <= acClass;
      virtAdrQ <= memRef.virtAdr;
    end
  end

  always_comb begin
    vmaOut.valid   = validQ;
    vmaOut.read    = readQ;
    vmaOut.write   = writeQ;
    vmaOut.user    = userQ;
    vmaOut.paged   = pagedQ;
    vmaOut.acRef   = acRefQ;
    vmaOut.virtAdr = virtAdrQ;
  end

endmodule

`default_nettype wire

/* pag.sv */
`timescale 1ns/1ps
`default_nettype none

module pag (
  input  wire                    eboxClk,
  input  wire                    rstN,
  input  memRefPkg::tMemRefCmd    memRef,
  input  logic                   ptWr,
  input  kl10TypesPkg::tPageNum   ptIndex,
  input  kl10TypesPkg::tPageEntry ptEntry,
  output memRefPkg::tPageLookup   lookupOut
);

  import kl10TypesPkg::*;

  tPageEntry pageMap [pageCount];
  logic [0:pageCount-1] present;

  tPageNum   lookupIdx;
  logic      validQ;
  logic      presentQ;
  tPageEntry entryQ;

  assign lookupIdx = memRef.virtAdr[18:26];

  // Map contents.
  always_ff @(posedge eboxClk) begin
    if (ptWr) begin
      pageMap[ptIndex] <= ptEntry;
    end
  end

  // Present marks, cleared by reset.
  always_ff @(posedge eboxClk) begin
    if (!rstN) begin
      present <= '0;
    end else if (ptWr) begin
      present[ptIndex] <= 1'b1;
    end
  end

  always_ff @(posedge eboxClk) begin
    if (!rstN) begin
      validQ <= 1'b0;
    end else begin
      validQ <= memRef.valid;
    end
  end

  // A same-cycle write to this index is seen by the next lookup.
  always_ff @(posedge eboxClk) begin
    if (memRef.valid) begin
      entryQ   <= pageMap[lookupIdx];
      presentQ <= present[lookupIdx];
    end
  end

  always_comb begin
    lookupOut.valid   = validQ;
    lookupOut.present = presentQ;
    lookupOut.entry   = entryQ;
  end

endmodule

`default_nettype wire

/* mcl.sv */
`timescale 1ns/1ps
`default_nettype none

module mcl (
  input  wire                       eboxClk,
  input  wire                       rstN,
  input  memRefPkg::tVmaState        vmaIn,
  input  memRefPkg::tPageLookup      lookupIn,
  input  logic                      mboxRespIn,
  output logic                      vmaACRef,
  output logic                      pageFail,
  output memRefPkg::tPageFailCode    pageFailCode,
  output logic                      eboxReq,
  output logic                      eboxRead,
  output logic                      eboxWrite,
  output logic                      eboxCache,
  output kl10TypesPkg::tPhysAdr      physAdr,
  output logic                      busy
);

  import kl10TypesPkg::*;
  import memRefPkg::*;

  typedef enum logic {
    sIdle,
    sReq
  } tMclState;

  tMclState     state;
  tPageEntry    entry;
  logic         launch;
  logic         takeAc;
  logic         takeReq;
  tPageFailCode failNext;
  tPhysAdr      nextAdr;
  logic         nextCache;

  assign entry  = lookupIn.entry;
  assign launch = vmaIn.valid && lookupIn.valid;

  // Outcome priority.
  always_comb begin
    takeAc    = 1'b0;
    takeReq   = 1'b0;
    failNext  = pfNone;
    nextAdr   = vmaIn.virtAdr[14:35];
    nextCache = 1'b1;
    if (vmaIn.acRef && (!vmaIn.user || !vmaIn.paged)) begin
      takeAc = 1'b1;
    end else if (!vmaIn.paged) begin
      takeReq = 1'b1;
    end else if (!lookupIn.present) begin
      failNext = pfUnmapped;
    end else if (!entry.accessible) begin
      failNext = pfNoAccess;
    end else if (vmaIn.user && !entry.public) begin
      failNext = pfNotPublic;
    end else if (vmaIn.write && !entry.writable) begin
      failNext = pfWriteProtect;
    end else begin
      takeReq   = 1'b1;
      nextAdr   = {entry.physPage, vmaIn.virtAdr[27:35]};
      nextCache = entry.cacheable;
    end
  end

  always_ff @(posedge eboxClk) begin
    if (!rstN) begin
      state        <= sIdle;
      vmaACRef     <= 1'b0;
      pageFail     <= 1'b0;
      pageFailCode <= pfNone;
      eboxRead     <= 1'b0;
      eboxWrite    <= 1'b0;
      eboxCache    <= 1'b0;
    end else begin
      vmaACRef     <= launch && takeAc;
      pageFail     <= launch && (failNext != pfNone);
      pageFailCode <= launch ? failNext : pfNone;
      case (state)
        sIdle: begin
          if (launch && takeReq) begin
            state     <= sReq;
            eboxRead  <= vmaIn.read;
            eboxWrite <= vmaIn.write;
            eboxCache <= nextCache;
          end
        end
        sReq: begin
          // Held until the memory box answers.
          if (mboxRespIn) begin
            state     <= sIdle;
            eboxRead  <= 1'b0;
            eboxWrite <= 1'b0;
            eboxCache <= 1'b0;
          end
        end
        default: state <= sIdle;
      endcase
    end
  end

  always_ff @(posedge eboxClk) begin
    if (launch && takeReq) begin
      physAdr <= nextAdr;
    end
  end

  assign eboxReq = (state == sReq);

  // Lookup stage through retirement.
  assign busy = vmaIn.valid || lookupIn.valid || vmaACRef || pageFail || eboxReq;

endmodule

`default_nettype wire

/* ebox.sv */
`timescale 1ns/1ps
`default_nettype none

module ebox (
  input  wire                       eboxClk,
  input  wire                       rstN,
  input  memRefPkg::tMemRefCmd       memRef,
  input  logic                      ptWr,
  input  kl10TypesPkg::tPageNum      ptIndex,
  input  kl10TypesPkg::tPageEntry    ptEntry,
  input  logic                      mboxRespIn,
  output logic                      vmaACRef,
  output logic                      pageFail,
  output memRefPkg::tPageFailCode    pageFailCode,
  output logic                      eboxReq,
  output logic                      eboxRead,
  output logic                      eboxWrite,
  output logic                      eboxCache,
  output kl10TypesPkg::tPhysAdr      physAdr,
  output logic                      busy
);

  import memRefPkg::*;

  tVmaState   vmaOut;
  tPageLookup lookupOut;

  vma vma0 (
    .eboxClk (eboxClk),
    .rstN    (rstN),
    .memRef  (memRef),
    .vmaOut  (vmaOut)
  );

  // Pager runs beside the VMA on the same strobe.
  pag pag0 (
    .eboxClk   (eboxClk),
    .rstN      (rstN),
    .memRef    (memRef),
    .ptWr      (ptWr),
    .ptIndex   (ptIndex),
    .ptEntry   (ptEntry),
    .lookupOut (lookupOut)
  );

  mcl mcl0 (
    .eboxClk      (eboxClk),
    .rstN         (rstN),
    .vmaIn        (vmaOut),
    .lookupIn     (lookupOut),
    .mboxRespIn   (mboxRespIn),
    .vmaACRef     (vmaACRef),
    .pageFail     (pageFail),
    .pageFailCode (pageFailCode),
    .eboxReq      (eboxReq),
    .eboxRead     (eboxRead),
    .eboxWrite    (eboxWrite),
    .eboxCache    (eboxCache),
    .physAdr      (physAdr),
    .busy         (busy)
  );

endmodule

`default_nettype wire

/* tbEboxChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module tbEboxChecker (
  input  wire                     eboxClk,
  input  wire                     rstN,
  input  memRefPkg::tMemRefCmd    memRef,
  input  logic                    ptWr,
  input  kl10TypesPkg::tPageNum   ptIndex,
  input  kl10TypesPkg::tPageEntry ptEntry,
  input  logic                    mboxRespIn,
  input  logic                    vmaACRef,
  input  logic                    pageFail,
  input  memRefPkg::tPageFailCode pageFailCode,
  input  logic                    eboxReq,
  input  logic                    eboxRead,
  input  logic                    eboxWrite,
  input  logic                    eboxCache,
  input  kl10TypesPkg::tPhysAdr   physAdr,
  input  logic                    busy,
  output int                      errorCount
);

  import kl10TypesPkg::*;
  import memRefPkg::*;

  typedef enum logic [1:0] {okNone, okAc, okFail, okReq} tKind;

  typedef struct packed {
    tKind         kind;
    tPageFailCode code;
    logic         read;
    logic         write;
    logic         cache;
    tPhysAdr      adr;
  } tOutcome;

  tPageEntry            mapModel [pageCount];
  logic [0:pageCount-1] mapValid;
  tOutcome              stage1;
  tOutcome              stage2;
  tOutcome              held;
  logic                 respSeen;
  logic                 expBusy;

  initial errorCount = 0;

  function automatic tOutcome predict(tMemRefCmd cmd);
    tOutcome   o;
    tPageNum   idx;
    tPageEntry e;
    o       = '0;
    o.kind  = okReq;
    o.code  = pfNone;
    o.read  = cmd.read;
    o.write = cmd.write;
    o.cache = 1'b1;
    o.adr   = cmd.virtAdr[14:35];
    idx     = cmd.virtAdr[18:26];
    e       = mapModel[idx];
    if (cmd.virtAdr[13:17] == 0 && cmd.virtAdr[18:35] <= acLimit && (!cmd.user || !cmd.paged)) begin
      o.kind = okAc;
    end else if (cmd.paged) begin
      if (!mapValid[idx]) begin
        o.code = pfUnmapped;
      end else if (!e.accessible) begin
        o.code = pfNoAccess;
      end else if (cmd.user && !e.public) begin
        o.code = pfNotPublic;
      end else if (cmd.write && !e.writable) begin
        o.code = pfWriteProtect;
      end else begin
        o.adr   = {e.physPage, cmd.virtAdr[27:35]};
        o.cache = e.cacheable;
      end
      if (o.code != pfNone) begin
        o.kind = okFail;
      end
    end
    return o;
  endfunction

  task automatic compare(string name, logic [31:0] expVal, logic [31:0] actVal);
    if (expVal !== actVal) begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, name, expVal, actVal);
    end
  endtask

  always @(negedge eboxClk) begin
    if (!rstN) begin
      mapValid = '0;
      stage1   = '0;
      stage2   = '0;
      held     = '0;
      respSeen = 1'b0;
    end else begin
      // Request retires the cycle after the response.
      if (stage2.kind == okReq) begin
        held = stage2;
      end else if (respSeen) begin
        held = '0;
      end
      expBusy = (stage1.kind != okNone) || (stage2.kind == okAc) ||
                (stage2.kind == okFail) || (held.kind == okReq);
      compare("vmaACRef", stage2.kind == okAc, vmaACRef);
      compare("pageFail", stage2.kind == okFail, pageFail);
      if (stage2.kind == okFail) begin
        compare("pageFailCode", stage2.code, pageFailCode);
      end
      compare("eboxReq", held.kind == okReq, eboxReq);
      compare("eboxRead", held.read, eboxRead);
      compare("eboxWrite", held.write, eboxWrite);
      compare("eboxCache", held.cache, eboxCache);
      if (held.kind == okReq) begin
        compare("physAdr", held.adr, physAdr);
      end
      compare("busy", expBusy, busy);
      respSeen = (held.kind == okReq) && mboxRespIn;
      stage2   = stage1;
      if (memRef.valid) begin
        stage1 = predict(memRef);
      end else begin
        stage1 = '0;
      end
      // Map write lands after a same-cycle lookup.
      if (ptWr) begin
        mapModel[ptIndex] = ptEntry;
        mapValid[ptIndex] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* tbEbox.sv */
`timescale 1ns/1ps
`default_nettype none

module tbEbox;

  import kl10TypesPkg::*;
  import memRefPkg::*;

  logic         eboxClk;
  logic         rstN;
  tMemRefCmd    memRef;
  logic         ptWr;
  tPageNum      ptIndex;
  tPageEntry    ptEntry;
  logic         mboxRespIn;
  logic         vmaACRef;
  logic         pageFail;
  tPageFailCode pageFailCode;
  logic         eboxReq;
  logic         eboxRead;
  logic         eboxWrite;
  logic         eboxCache;
  tPhysAdr      physAdr;
  logic         busy;

  int      errorCount;
  int      timeoutCount;
  int      seed;
  int      respSeed;
  int      respDelay;
  tPageNum loaded [$];

  ebox DUT (.*);

  tbEboxChecker checkerInst (.*);

  initial begin
    eboxClk = 1'b0;
    forever #4 eboxClk = ~eboxClk;
  end

  function automatic int randBelow(int n);
    return {$random(seed)} % n;
  endfunction

  function automatic tPageEntry randEntry();
    tPageEntry e;
    e.accessible = randBelow(4) != 0;
    e.public     = randBelow(4) != 0;
    e.writable   = randBelow(4) != 0;
    e.cacheable  = randBelow(2) != 0;
    e.physPage   = tPhysPage'(randBelow(8192));
    return e;
  endfunction

  function automatic tMemRefCmd makeRef();
    tMemRefCmd c;
    int        mode;
    tPageNum   pg;
    c       = '0;
    c.valid = 1'b1;
    c.read  = randBelow(2) == 1;
    c.write = !c.read;
    c.user  = randBelow(2) == 1;
    c.paged = randBelow(4) != 0;
    mode    = randBelow(8);
    if (mode < 5 && loaded.size() > 0) begin
      pg = loaded[randBelow(loaded.size())];
    end else begin
      pg = tPageNum'(randBelow(pageCount));
    end
    if (mode == 0) begin
      c.virtAdr[32:35] = 4'(randBelow(16));
    end else begin
      c.virtAdr[13:17] = 5'(randBelow(4));
      c.virtAdr[18:26] = pg;
      c.virtAdr[27:35] = 9'(randBelow(512));
    end
    return c;
  endfunction

  // Memory box answers each request after 1 to 6 cycles.
  always @(posedge eboxClk) begin
    if (!rstN) begin
      mboxRespIn <= 1'b0;
      respDelay = 0;
    end else if (mboxRespIn) begin
      mboxRespIn <= 1'b0;
    end else if (eboxReq) begin
      if (respDelay == 0) begin
        respDelay = 1 + ({$random(respSeed)} % 6);
      end
      respDelay = respDelay - 1;
      if (respDelay == 0) begin
        mboxRespIn <= 1'b1;
      end
    end
  end

  task automatic waitIdle();
    int cycles;
    cycles = 0;
    @(posedge eboxClk);
    while (busy && cycles < 40) begin
      @(posedge eboxClk);
      cycles++;
    end
    if (busy) begin
      timeoutCount++;
      $display("Timeout: busy still high after %0d cycles at %0t", cycles, $time);
    end
  endtask

  task automatic loadEntry(tPageNum idx, tPageEntry e);
    ptWr    <= 1'b1;
    ptIndex <= idx;
    ptEntry <= e;
    loaded.push_back(idx);
    @(posedge eboxClk);
    ptWr <= 1'b0;
  endtask

  task automatic issueRef(tMemRefCmd cmd);
    memRef <= cmd;
    @(posedge eboxClk);
    memRef <= '0;
    waitIdle();
  endtask

  // Map write and lookup in the same cycle.
  task automatic loadDuringRef(tPageNum idx, tPageEntry e, tMemRefCmd cmd);
    ptWr    <= 1'b1;
    ptIndex <= idx;
    ptEntry <= e;
    memRef  <= cmd;
    @(posedge eboxClk);
    ptWr   <= 1'b0;
    memRef <= '0;
    waitIdle();
  endtask

  initial begin
    tMemRefCmd cmd;
    tPageNum   idx;
    seed         = 80;
    respSeed     = 80;
    timeoutCount = 0;
    rstN         = 1'b0;
    memRef       = '0;
    ptWr         = 1'b0;
    ptIndex      = '0;
    ptEntry      = '0;
    mboxRespIn   = 1'b0;
    repeat (3) @(posedge eboxClk);
    rstN <= 1'b1;
    // Map is empty, so user paged references fault as unmapped.
    for (int n = 0; n < 8; n++) begin
      cmd       = makeRef();
      cmd.paged = 1'b1;
      cmd.user  = 1'b1;
      issueRef(cmd);
    end
    loadEntry('0, randEntry());
    for (int n = 0; n < 39; n++) begin
      loadEntry(tPageNum'(randBelow(pageCount)), randEntry());
    end
    for (int n = 0; n < 300 && timeoutCount == 0; n++) begin
      if (randBelow(10) == 0) begin
        // Remap a page while it is looked up, then touch it again.
        idx                = loaded[randBelow(loaded.size())];
        cmd                = makeRef();
        cmd.paged          = 1'b1;
        cmd.virtAdr[18:26] = idx;
        loadDuringRef(idx, randEntry(), cmd);
        issueRef(cmd);
      end
      issueRef(makeRef());
    end
    @(negedge eboxClk);
    $display("Errors: %0d value mismatches, %0d timeouts", errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
kl10TypesPkg.sv
memRefPkg.sv
vma.sv
pag.sv
mcl.sv
ebox.sv
tbEboxChecker.sv
tbEbox.sv
